//--- verilog/cart_consts.svh
// Cartridge load constants
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// bus widths
`define CART_ADDR_W 25
`define CART_WORD_W 16

// load_index value of a cheat download
`define CART_INDEX_CODE 8'hFF

// header byte offsets
`define CART_HDR_REGION0 25'h1F0
`define CART_HDR_REGION1 25'h1F2
`define CART_HDR_END 25'h200

// serial field, first and last word, then the word that triggers the lookup
`define CART_SERIAL_FIRST 25'h182
`define CART_SERIAL_LAST 25'h18A
`define CART_SERIAL_CHECK 25'h18C

// light gun sensor delays
`define CART_GUN_DELAY_DEFAULT 8'd44
`define CART_GUN_DELAY_LE 8'd52
`define CART_GUN_DELAY_BC 8'd100

// quirk table serials
`define CART_SN_SRAM_0 "T-081276"
`define CART_SN_SRAM_1 "T-81406 "
`define CART_SN_EEPROM_0 "MK-1215 "
`define CART_SN_EEPROM_1 "G-4060  "
`define CART_SN_NORAM "T-113016"
`define CART_SN_FIFO "T-89016 "
`define CART_SN_SVP "MK-1229 "
`define CART_SN_GUN_LE "T-95096-"
`define CART_SN_GUN_BC "MK-1533 "

`endif

//--- verilog/cart_pkg.sv
// Cartridge load types
`default_nettype none

`include "cart_consts.svh"

package cart_pkg;

	// one loader word, seen as a number or as two ascii characters
	typedef union packed {
		logic [`CART_WORD_W-1:0] raw;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} chars;
	} load_word_u;

	// cheat record, integer fields kept in the order the loader sends them
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// what the decoder saw in the previous cycle
	typedef enum logic [1:0] {
		kind_rom,
		kind_code,
		kind_code_first,
		kind_none
	} word_kind_e;

endpackage

`default_nettype wire

//--- verilog/load_decode.sv
// Load word decoder
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module load_decode (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    loading,
	input  logic [7:0]              load_index,
	input  logic [`CART_ADDR_W-1:0] load_addr,
	input  cart_pkg::load_word_u    load_data,
	input  logic                    load_wr,
	input  logic                    load_wait,
	output cart_pkg::word_kind_e    kind,
	output logic [`CART_ADDR_W-1:0] word_addr,
	output cart_pkg::load_word_u    word,
	output logic                    load_start,
	output logic                    load_end
);

	logic accept;
	logic is_code;
	logic loading_q;

	// a word is taken only while a download runs and nothing holds the loader off
	assign accept = loading & load_wr & ~load_wait;
	// all ones index means a cheat file, anything else is rom
	assign is_code = (load_index == `CART_INDEX_CODE);

	//////////////////////////////////////////////////////////////////////
	// word class, valid for exactly one cycle per accepted word
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			kind <= cart_pkg::kind_none;
		end else if (!accept) begin
			kind <= cart_pkg::kind_none;
		end else if (!is_code) begin
			kind <= cart_pkg::kind_rom;
		end else if (load_addr == '0) begin
			// record at address zero also restarts the cheat list
			kind <= cart_pkg::kind_code_first;
		end else begin
			kind <= cart_pkg::kind_code;
		end
	end

	// address and data ride along with kind
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			word_addr <= load_addr;
			word <= load_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// download start and end strobes, shared by all execute blocks
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			loading_q <= 1'b0;
			load_start <= 1'b0;
			load_end <= 1'b0;
		end else begin
			loading_q <= loading;
			load_start <= loading & ~loading_q;
			load_end <= ~loading & loading_q;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cheat_assembler.sv
// Cheat record assembler
`timescale 1ns/1ps
`default_nettype none

module cheat_assembler (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  cart_pkg::word_kind_e   kind,
	input  logic [3:0]             word_addr,
	input  cart_pkg::load_word_u   word,
	output cart_pkg::cheat_code_t  code,
	output logic                   code_valid,
	output logic                   code_clear
);

	logic is_cheat;

	assign is_cheat = (kind == cart_pkg::kind_code) || (kind == cart_pkg::kind_code_first);

	// byte offset inside the 16 byte record picks the half word
	always_ff @(posedge clk_sys) begin
		if (is_cheat) begin
			case (word_addr)
				4'd0:  code.flags[15:0] <= word.raw;
				4'd2:  code.flags[31:16] <= word.raw;
				4'd4:  code.address[15:0] <= word.raw;
				4'd6:  code.address[31:16] <= word.raw;
				4'd8:  code.compare[15:0] <= word.raw;
				4'd10: code.compare[31:16] <= word.raw;
				4'd12: code.replace[15:0] <= word.raw;
				4'd14: code.replace[31:16] <= word.raw;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// strobes
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			// replace high is the last half, record is complete with it
			code_valid <= is_cheat && (word_addr == 4'd14);
			code_clear <= (kind == cart_pkg::kind_code_first);
		end
	end

	// each record closes once, and the loader sends at most one word per cycle
	a_valid_single: assert property (@(posedge clk_sys) disable iff (rst)
		code_valid |=> !code_valid)
		else $error("code_valid held for two cycles");

endmodule

`default_nettype wire

//--- verilog/region_detect.sv
// Header region detector
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module region_detect (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  cart_pkg::word_kind_e    kind,
	input  logic [`CART_ADDR_W-1:0] word_addr,
	input  cart_pkg::load_word_u    word,
	input  logic                    load_start,
	input  logic                    load_end,
	output logic                    region_j,
	output logic                    region_u,
	output logic                    region_e,
	output logic                    hdr_ready
);

	logic [3:0] hex_val;
	logic       at_region0;
	logic       at_region1;

	// 'A'..'F' low nibble minus 7 gives the hex digit value 10..15
	assign hex_val = word.chars.lo[3:0] - 4'd7;
	assign at_region0 = (kind == cart_pkg::kind_rom) && (word_addr == `CART_HDR_REGION0);
	assign at_region1 = (kind == cart_pkg::kind_rom) && (word_addr == `CART_HDR_REGION1);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			region_j <= 1'b0;
			region_u <= 1'b0;
			region_e <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			// new download starts with no region known
			if (load_start) begin
				region_j <= 1'b0;
				region_u <= 1'b0;
				region_e <= 1'b0;
			end
			if (load_end) hdr_ready <= 1'b0;

			//////////////////////////////////////////////////////////////
			// low byte, letters at both words, digit code only at the first
			if (at_region0 || at_region1) begin
				if (word.chars.lo == "J") region_j <= 1'b1;
				else if (word.chars.lo == "U") region_u <= 1'b1;
				else if (word.chars.lo == "E") region_e <= 1'b1;
				else if (at_region0 && word.chars.lo >= "0" && word.chars.lo <= "9") begin
					// digit is a bit mask, bit 1 unused
					region_e <= word.chars.lo[3];
					region_u <= word.chars.lo[2];
					region_j <= word.chars.lo[0];
				end else if (at_region0 && word.chars.lo >= "A" && word.chars.lo <= "F") begin
					region_e <= hex_val[3];
					region_u <= hex_val[2];
					region_j <= hex_val[0];
				end
			end

			// high byte only ever adds a letter
			if (at_region0 || at_region1) begin
				if (word.chars.hi == "J") region_j <= 1'b1;
				else if (word.chars.hi == "U") region_u <= 1'b1;
				else if (word.chars.hi == "E") region_e <= 1'b1;
			end

			// header fully seen
			if (kind == cart_pkg::kind_rom && word_addr == `CART_HDR_END) hdr_ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/quirk_lookup.sv
// Cart serial quirk lookup
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module quirk_lookup (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  cart_pkg::word_kind_e    kind,
	input  logic [`CART_ADDR_W-1:0] word_addr,
	input  cart_pkg::load_word_u    word,
	input  logic                    load_start,
	output logic                    sram_quirk,
	output logic                    eeprom_quirk,
	output logic                    noram_quirk,
	output logic                    fifo_quirk,
	output logic                    svp_quirk,
	output logic                    gun_type,
	output logic [7:0]              gun_sensor_delay
);

	logic        is_rom;
	// eight characters, first one in the top byte
	logic [63:0] serial;

	assign is_rom = (kind == cart_pkg::kind_rom);

	//////////////////////////////////////////////////////////////////////
	// serial capture
	always_ff @(posedge clk_sys) begin
		if (is_rom) begin
			if (word_addr == `CART_SERIAL_FIRST) serial[63:56] <= word.chars.hi;
			if (word_addr == `CART_SERIAL_FIRST + 25'd2) serial[55:40] <= word.raw;
			if (word_addr == `CART_SERIAL_FIRST + 25'd4) serial[39:24] <= word.raw;
			if (word_addr == `CART_SERIAL_FIRST + 25'd6) serial[23:8] <= word.raw;
			if (word_addr == `CART_SERIAL_LAST) serial[7:0] <= word.chars.lo;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// table lookup, one word after the serial is complete
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sram_quirk <= 1'b0;
			eeprom_quirk <= 1'b0;
			noram_quirk <= 1'b0;
			fifo_quirk <= 1'b0;
			svp_quirk <= 1'b0;
			gun_type <= 1'b0;
			gun_sensor_delay <= `CART_GUN_DELAY_DEFAULT;
		end else begin
			if (load_start) begin
				sram_quirk <= 1'b0;
				eeprom_quirk <= 1'b0;
				noram_quirk <= 1'b0;
				fifo_quirk <= 1'b0;
				svp_quirk <= 1'b0;
			end
			if (is_rom && word_addr == `CART_SERIAL_CHECK) begin
				case (serial)
					`CART_SN_SRAM_0, `CART_SN_SRAM_1: sram_quirk <= 1'b1;
					`CART_SN_EEPROM_0, `CART_SN_EEPROM_1: eeprom_quirk <= 1'b1;
					// fake ram check in the game, must see no ram
					`CART_SN_NORAM: noram_quirk <= 1'b1;
					`CART_SN_FIFO: fifo_quirk <= 1'b1;
					`CART_SN_SVP: svp_quirk <= 1'b1;
					default: ;
				endcase

				// light gun type and timing, defaults for everything else
				if (serial == `CART_SN_GUN_LE) begin
					gun_type <= 1'b1;
					gun_sensor_delay <= `CART_GUN_DELAY_LE;
				end else if (serial == `CART_SN_GUN_BC) begin
					gun_type <= 1'b0;
					gun_sensor_delay <= `CART_GUN_DELAY_BC;
				end else begin
					gun_type <= 1'b0;
					gun_sensor_delay <= `CART_GUN_DELAY_DEFAULT;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/rom_write_port.sv
// ROM memory write port
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module rom_write_port (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  cart_pkg::word_kind_e    kind,
	input  logic [`CART_ADDR_W-1:0] word_addr,
	input  cart_pkg::load_word_u    word,
	input  logic                    mem_ack,
	output logic [`CART_ADDR_W-2:0] mem_addr,
	output logic [`CART_WORD_W-1:0] mem_data,
	output logic                    mem_req,
	output logic                    load_wait
);

	logic rom_word;
	// write handed to memory, ack not yet back
	logic busy;

	assign rom_word = (kind == cart_pkg::kind_rom);
	// hold off the loader already in the cycle the word is classified
	assign load_wait = busy | rom_word;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			busy <= 1'b0;
			mem_req <= 1'b0;
		end else if (rom_word) begin
			busy <= 1'b1;
			mem_req <= ~mem_req;
		end else if (busy && (mem_ack == mem_req)) begin
			busy <= 1'b0;
		end
	end

	// word address, rom is big endian so swap the bytes
	always_ff @(posedge clk_sys) begin
		if (rom_word) begin
			mem_addr <= word_addr[`CART_ADDR_W-1:1];
			mem_data <= {word.chars.lo, word.chars.hi};
		end
	end

	// load_wait must have stopped the loader before the next rom word
	a_no_overlap: assert property (@(posedge clk_sys) disable iff (rst)
		rom_word |-> !busy)
		else $error("rom word while memory write outstanding");

endmodule

`default_nettype wire

//--- verilog/cart_loader.sv
// Cartridge load path top
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    rst,
	// loader side
	input  logic                    loading,
	input  logic [7:0]              load_index,
	input  logic [`CART_ADDR_W-1:0] load_addr,
	input  logic [`CART_WORD_W-1:0] load_data,
	input  logic                    load_wr,
	output logic                    load_wait,
	// memory side
	output logic [`CART_ADDR_W-2:0] mem_addr,
	output logic [`CART_WORD_W-1:0] mem_data,
	output logic                    mem_req,
	input  logic                    mem_ack,
	// cheats
	output cart_pkg::cheat_code_t   code,
	output logic                    code_valid,
	output logic                    code_clear,
	// header results
	output logic                    region_j,
	output logic                    region_u,
	output logic                    region_e,
	output logic                    hdr_ready,
	output logic                    sram_quirk,
	output logic                    eeprom_quirk,
	output logic                    noram_quirk,
	output logic                    fifo_quirk,
	output logic                    svp_quirk,
	output logic                    gun_type,
	output logic [7:0]              gun_sensor_delay
);

	cart_pkg::word_kind_e    kind;
	logic [`CART_ADDR_W-1:0] word_addr;
	cart_pkg::load_word_u    word;
	logic                    load_start;
	logic                    load_end;

	//////////////////////////////////////////////////////////////////////
	// decode stage
	load_decode load_decode_i (
		.clk_sys(clk_sys), .rst(rst), .loading(loading), .load_index(load_index),
		.load_addr(load_addr), .load_data(load_data), .load_wr(load_wr),
		.load_wait(load_wait), .kind(kind), .word_addr(word_addr), .word(word),
		.load_start(load_start), .load_end(load_end)
	);

	//////////////////////////////////////////////////////////////////////
	// execute blocks
	cheat_assembler cheat_assembler_i (
		.clk_sys(clk_sys), .rst(rst), .kind(kind), .word_addr(word_addr[3:0]),
		.word(word), .code(code), .code_valid(code_valid), .code_clear(code_clear)
	);

	region_detect region_detect_i (
		.clk_sys(clk_sys), .rst(rst), .kind(kind), .word_addr(word_addr), .word(word),
		.load_start(load_start), .load_end(load_end), .region_j(region_j),
		.region_u(region_u), .region_e(region_e), .hdr_ready(hdr_ready)
	);

	quirk_lookup quirk_lookup_i (
		.clk_sys(clk_sys), .rst(rst), .kind(kind), .word_addr(word_addr), .word(word),
		.load_start(load_start), .sram_quirk(sram_quirk), .eeprom_quirk(eeprom_quirk),
		.noram_quirk(noram_quirk), .fifo_quirk(fifo_quirk), .svp_quirk(svp_quirk),
		.gun_type(gun_type), .gun_sensor_delay(gun_sensor_delay)
	);

	// rom words out to memory, back-pressure to the loader
	rom_write_port rom_write_port_i (
		.clk_sys(clk_sys), .rst(rst), .kind(kind), .word_addr(word_addr), .word(word),
		.mem_ack(mem_ack), .mem_addr(mem_addr), .mem_data(mem_data), .mem_req(mem_req),
		.load_wait(load_wait)
	);

endmodule

`default_nettype wire

//--- bench/cart_loader_tb.sv
// Cartridge loader testbench
`timescale 1ns/1ps
`default_nettype none

`include "cart_consts.svh"

module cart_loader_tb;

	// cycles any single wait may take
	localparam int wait_limit = 200;

	logic                    clk_sys;
	logic                    rst;
	logic                    loading;
	logic [7:0]              load_index;
	logic [`CART_ADDR_W-1:0] load_addr;
	logic [`CART_WORD_W-1:0] load_data;
	logic                    load_wr;
	logic                    load_wait;
	logic [`CART_ADDR_W-2:0] mem_addr;
	logic [`CART_WORD_W-1:0] mem_data;
	logic                    mem_req;
	logic                    mem_ack;
	cart_pkg::cheat_code_t   code;
	logic                    code_valid;
	logic                    code_clear;
	logic                    region_j;
	logic                    region_u;
	logic                    region_e;
	logic                    hdr_ready;
	logic                    sram_quirk;
	logic                    eeprom_quirk;
	logic                    noram_quirk;
	logic                    fifo_quirk;
	logic                    svp_quirk;
	logic                    gun_type;
	logic [7:0]              gun_sensor_delay;

	integer seed = 32'h754a5f5e;
	// expected memory writes, word address above swapped data
	logic [39:0] rom_expect[$];
	cart_pkg::cheat_code_t code_expect;
	int valid_count;
	int clear_count;

	cart_loader cart_loader_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// check helpers
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
			else fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// returns at a falling edge with the loader free
	task automatic wait_load_idle();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (load_wait) begin
			n++;
			if (n > wait_limit) fail_run("timeout waiting for load_wait to fall");
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_hdr_ready(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (hdr_ready !== level) begin
			n++;
			if (n > wait_limit) fail_run("timeout waiting for hdr_ready to change");
			@(negedge clk_sys);
		end
	endtask

	// one word, accepted at the second rising edge since load_wait is low
	task automatic send_word(input logic [`CART_ADDR_W-1:0] addr, input logic [15:0] data);
		wait_load_idle();
		@(posedge clk_sys);
		load_wr <= 1'b1;
		load_addr <= addr;
		load_data <= data;
		// rom word lands at the word address, big endian bytes swapped
		if (load_index != `CART_INDEX_CODE)
			rom_expect.push_back({addr[`CART_ADDR_W-1:1], data[7:0], data[15:8]});
		@(posedge clk_sys);
		load_wr <= 1'b0;
	endtask

	task automatic check_header(input logic j, input logic u, input logic e,
			input logic sram, input logic gun, input logic [7:0] delay);
		@(negedge clk_sys);
		check_value("region_j", region_j, j);
		check_value("region_u", region_u, u);
		check_value("region_e", region_e, e);
		check_value("sram_quirk", sram_quirk, sram);
		check_value("eeprom_quirk", eeprom_quirk, 0);
		check_value("noram_quirk", noram_quirk, 0);
		check_value("fifo_quirk", fifo_quirk, 0);
		check_value("svp_quirk", svp_quirk, 0);
		check_value("gun_type", gun_type, gun);
		check_value("gun_sensor_delay", gun_sensor_delay, delay);
	endtask

	//////////////////////////////////////////////////////////////////////
	// downloads
	task automatic cart_load(input logic [63:0] serial, input logic [15:0] region0,
			input logic [15:0] region1);
		logic [`CART_ADDR_W-1:0] a;
		@(posedge clk_sys);
		load_index <= 8'h00;
		loading <= 1'b1;
		// plain rom words ahead of the header
		for (a = 0; a < 25'h10; a = a + 2) send_word(a, 16'($random(seed)));
		// first character high at 0x182, last one low at 0x18a
		send_word(`CART_SERIAL_FIRST, {serial[63:56], 8'h20});
		send_word(25'h184, serial[55:40]);
		send_word(25'h186, serial[39:24]);
		send_word(25'h188, serial[23:8]);
		send_word(`CART_SERIAL_LAST, {8'h20, serial[7:0]});
		send_word(`CART_SERIAL_CHECK, 16'h2020);
		send_word(`CART_HDR_REGION0, region0);
		send_word(`CART_HDR_REGION1, region1);
		@(negedge clk_sys);
		check_value("hdr_ready", hdr_ready, 0);
		send_word(`CART_HDR_END, 16'h0000);
		wait_hdr_ready(1'b1);
		wait_load_idle();
		@(posedge clk_sys);
		loading <= 1'b0;
	endtask

	task automatic cheat_load();
		logic [15:0] half [8];
		int i;
		int n;
		for (i = 0; i < 8; i++) half[i] = 16'($random(seed));
		// low half first, flags then address, compare, replace
		code_expect.flags = {half[1], half[0]};
		code_expect.address = {half[3], half[2]};
		code_expect.compare = {half[5], half[4]};
		code_expect.replace = {half[7], half[6]};
		@(posedge clk_sys);
		load_index <= `CART_INDEX_CODE;
		loading <= 1'b1;
		for (i = 0; i < 8; i++) send_word(25'(i * 2), half[i]);
		n = 0;
		@(negedge clk_sys);
		while (valid_count == 0) begin
			n++;
			if (n > wait_limit) fail_run("no code_valid pulse after the cheat record");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		loading <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory side
	// echo the request toggle after 0 to 7 extra cycles
	initial begin
		int delay;
		forever begin
			@(negedge clk_sys);
			if (!rst && mem_req !== mem_ack) begin
				delay = $random(seed) & 7;
				repeat (delay) @(posedge clk_sys);
				@(posedge clk_sys);
				mem_ack <= mem_req;
			end
		end
	end

	// each toggle is one write, matched in order against the rom words sent
	initial begin
		logic req_last;
		logic [39:0] exp;
		req_last = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!rst && mem_req !== req_last) begin
				req_last = mem_req;
				assert (rom_expect.size() > 0) else fail_run("memory write with no rom word sent");
				exp = rom_expect.pop_front();
				check_value("mem_addr", mem_addr, exp[39:16]);
				check_value("mem_data", mem_data, exp[15:0]);
			end
		end
	end

	// cheat strobes
	initial begin
		forever begin
			@(negedge clk_sys);
			if (!rst && code_valid) begin
				valid_count++;
				check_value("code.flags", code.flags, code_expect.flags);
				check_value("code.address", code.address, code_expect.address);
				check_value("code.compare", code.compare, code_expect.compare);
				check_value("code.replace", code.replace, code_expect.replace);
			end
			if (!rst && code_clear) clear_count++;
		end
	end

	a_req_held: assert property (@(posedge clk_sys) disable iff (rst)
		(mem_req != mem_ack) |=> $stable(mem_req))
		else fail_run("mem_req toggled while a memory write was outstanding");

	a_cheat_no_wait: assert property (@(posedge clk_sys) disable iff (rst)
		(loading && load_index == `CART_INDEX_CODE) |-> !load_wait)
		else fail_run("load_wait rose during a cheat download");

	//////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		rst = 1'b1;
		loading = 1'b0;
		load_index = 8'h00;
		load_addr = '0;
		load_data = '0;
		load_wr = 1'b0;
		mem_ack = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;

		// state straight out of reset
		check_header(0, 0, 0, 0, 0, 8'd44);
		check_value("load_wait", load_wait, 0);
		check_value("mem_req", mem_req, 0);
		check_value("code_valid", code_valid, 0);
		check_value("code_clear", code_clear, 0);
		check_value("hdr_ready", hdr_ready, 0);

		// letters JU then E, sram serial
		cart_load("T-081276", {"J", "U"}, {"E", " "});
		check_header(1, 1, 1, 1, 0, 8'd44);
		wait_hdr_ready(1'b0);
		// digit 4 in the low byte, usa only
		cart_load("T-95096-", {" ", "4"}, "  ");
		check_header(0, 1, 0, 0, 1, 8'd52);
		wait_hdr_ready(1'b0);
		// serial not in the table
		cart_load("X-123456", "  ", "  ");
		check_header(0, 0, 0, 0, 0, 8'd44);
		wait_hdr_ready(1'b0);

		cheat_load();
		@(negedge clk_sys);
		assert (rom_expect.size() == 0) else fail_run("rom words never written to memory");
		check_value("code_valid pulses", 64'(valid_count), 1);
		check_value("code_clear pulses", 64'(clear_count), 1);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/cart_pkg.sv
verilog/load_decode.sv
verilog/cheat_assembler.sv
verilog/region_detect.sv
verilog/quirk_lookup.sv
verilog/rom_write_port.sv
verilog/cart_loader.sv
bench/cart_loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the cart loader testbench with verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module cart_loader_tb -o cart_loader_sim
./obj_dir/cart_loader_sim | tee sim.log
if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
